/* common/trap_defs.svh */
// trap block parameters
// data width, machine CSR addresses, cause codes and pipeline opcode tags

`ifndef TRAP_DEFS_SVH
`define TRAP_DEFS_SVH

// data path width
`define TRAP_XLEN 64

// machine CSR addresses
`define TRAP_CSR_MSTATUS 12'h300
`define TRAP_CSR_MTVEC   12'h305
`define TRAP_CSR_MEPC    12'h341
`define TRAP_CSR_MCAUSE  12'h342

// mcause values
`define TRAP_CAUSE_ECALL_M 64'd11
`define TRAP_CAUSE_TIMER_M 64'h8000_0000_0000_0007  // interrupt bit + 7

// pipeline request tags, anything else is a timer interrupt
`define TRAP_OP_ECALL 8'h01
`define TRAP_OP_MRET  8'h02

// mode encodings for mstatus.MPP
`define TRAP_MODE_U 2'b00
`define TRAP_MODE_M 2'b11

`endif

/* common/trap_pkg.sv */
// trap block types
// trap kind and the two views of the mstatus word

`default_nettype none

`include "trap_defs.svh"

package trap_pkg;

  // what the sequencer is handling
  typedef enum logic [1:0] {
    kind_none  = 2'd0,
    kind_ecall = 2'd1,
    kind_timer = 2'd2,
    kind_mret  = 2'd3
  } trap_kind_e;

  // mstatus bit layout, only mpp/mpie/mie are implemented
  typedef struct packed {
    logic [`TRAP_XLEN-1:13] rsvd_hi;
    logic [1:0]             mpp;       // 12..11
    logic [2:0]             rsvd_10_8;
    logic                   mpie;      // 7
    logic [2:0]             rsvd_6_4;
    logic                   mie;       // 3
    logic [2:0]             rsvd_2_0;
  } mstatus_fields_t;

  // raw word or decoded fields
  typedef union packed {
    logic [`TRAP_XLEN-1:0] raw;
    mstatus_fields_t       f;
  } mstatus_t;

endpackage

`default_nettype wire

/* common/csr_access_if.sv */
// CSR access port between the trap sequencer and the CSR file
// one access at a time, read data comes back a cycle later

`timescale 1ns/10ps
`default_nettype none

`include "trap_defs.svh"

interface csr_access_if;

  logic [11:0]           addr;
  logic                  ren;    // never together with wen
  logic                  wen;
  logic [`TRAP_XLEN-1:0] wdata;
  logic [`TRAP_XLEN-1:0] rdata;  // registered in the CSR file

  modport master (
    output addr, ren, wen, wdata,
    input  rdata
  );

  modport slave (
    input  addr, ren, wen, wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* trap_ctrl/trap_sequencer.sv */
// trap sequencer
// walks the CSR accesses for ecall/timer entry and mret, then holds the redirect

`timescale 1ns/10ps
`default_nettype none

`include "trap_defs.svh"

module trap_sequencer (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        i_ena,
  input  wire  [7:0]                 i_opcode,
  input  wire  [`TRAP_XLEN-1:0]      i_pc,
  input  wire                        i_ack,
  output logic                       o_redirect,
  output logic [`TRAP_XLEN-1:0]      o_target,
  csr_access_if.master               csr
);

  // one state per CSR access, plus idle and the redirect wait
  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_wr_mepc    = 3'd1,
    st_wr_mcause  = 3'd2,
    st_rd_mtvec   = 3'd3,
    st_rd_mstatus = 3'd4,
    st_rd_mepc    = 3'd5,
    st_wr_mstatus = 3'd6,
    st_resp       = 3'd7
  } state_e;

  state_e                 state;
  state_e                 next_access;
  logic                   phase;        // 0 issue, 1 capture/release
  trap_pkg::trap_kind_e   req_kind;
  trap_pkg::trap_kind_e   kind_q;
  logic [`TRAP_XLEN-1:0]  pc_q;
  logic [`TRAP_XLEN-1:0]  cause_q;
  logic [`TRAP_XLEN-1:0]  target_q;     // mtvec on entry, mepc on return
  trap_pkg::mstatus_t     mstatus_q;
  trap_pkg::mstatus_t     mstatus_new;

  // decode the request tag
  always_comb begin
    case (i_opcode)
      `TRAP_OP_ECALL: req_kind = trap_pkg::kind_ecall;
      `TRAP_OP_MRET:  req_kind = trap_pkg::kind_mret;
      default:        req_kind = trap_pkg::kind_timer;
    endcase
  end

  // access order
  always_comb begin
    case (state)
      st_wr_mepc:    next_access = st_wr_mcause;
      st_wr_mcause:  next_access = st_rd_mtvec;
      st_rd_mtvec:   next_access = st_rd_mstatus;
      st_rd_mstatus: next_access = (kind_q == trap_pkg::kind_mret) ? st_rd_mepc : st_wr_mstatus;
      st_rd_mepc:    next_access = st_wr_mstatus;
      st_wr_mstatus: next_access = st_resp;
      default:       next_access = st_idle;
    endcase
  end

  // new mstatus from the saved copy
  always_comb begin
    mstatus_new = mstatus_q;
    if (kind_q == trap_pkg::kind_mret) begin
      mstatus_new.f.mie  = mstatus_q.f.mpie;
      mstatus_new.f.mpie = 1'b1;
      mstatus_new.f.mpp  = `TRAP_MODE_U;
    end else begin
      mstatus_new.f.mpp  = `TRAP_MODE_M;
      mstatus_new.f.mpie = mstatus_q.f.mie;
      mstatus_new.f.mie  = 1'b0;
    end
  end

  // bus drive, strobes only in the issue phase
  always_comb begin
    csr.addr  = '0;
    csr.ren   = 1'b0;
    csr.wen   = 1'b0;
    csr.wdata = '0;
    case (state)
      st_wr_mepc: begin
        csr.addr  = `TRAP_CSR_MEPC;
        csr.wen   = ~phase;
        csr.wdata = pc_q;
      end
      st_wr_mcause: begin
        csr.addr  = `TRAP_CSR_MCAUSE;
        csr.wen   = ~phase;
        csr.wdata = cause_q;
      end
      st_rd_mtvec: begin
        csr.addr = `TRAP_CSR_MTVEC;
        csr.ren  = ~phase;
      end
      st_rd_mstatus: begin
        csr.addr = `TRAP_CSR_MSTATUS;
        csr.ren  = ~phase;
      end
      st_rd_mepc: begin
        csr.addr = `TRAP_CSR_MEPC;
        csr.ren  = ~phase;
      end
      st_wr_mstatus: begin
        csr.addr  = `TRAP_CSR_MSTATUS;
        csr.wen   = ~phase;
        csr.wdata = mstatus_new.raw;
      end
      default: ;
    endcase
  end

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      phase      <= 1'b0;
      kind_q     <= trap_pkg::kind_none;
      o_redirect <= 1'b0;
      o_target   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (i_ena) begin
            kind_q <= req_kind;
            phase  <= 1'b0;
            state  <= (req_kind == trap_pkg::kind_mret) ? st_rd_mstatus : st_wr_mepc;
          end
        end
        st_resp: begin
          if (!o_redirect) begin
            o_redirect <= 1'b1;
            o_target   <= target_q;
          end else if (i_ack) begin
            o_redirect <= 1'b0;  // handshake done
            state      <= st_idle;
          end
        end
        default: begin
          phase <= ~phase;
          if (phase) begin
            state <= next_access;
          end
        end
      endcase
    end
  end

  // request payload and read captures
  always_ff @(posedge clk) begin
    if (state == st_idle && i_ena) begin
      pc_q    <= i_pc;
      cause_q <= (req_kind == trap_pkg::kind_ecall) ? `TRAP_CAUSE_ECALL_M : `TRAP_CAUSE_TIMER_M;
    end
    if (phase) begin
      case (state)
        st_rd_mtvec:   target_q      <= csr.rdata;
        st_rd_mepc:    target_q      <= csr.rdata;
        st_rd_mstatus: mstatus_q.raw <= csr.rdata;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* csr_file/machine_csr_file.sv */
// machine CSR file
// mstatus/mepc/mcause/mtvec with a trap port and a pipeline port

`timescale 1ns/10ps
`default_nettype none

`include "trap_defs.svh"

module machine_csr_file (
  input  wire                        clk,
  input  wire                        rst,
  csr_access_if.slave                trap,
  input  wire  [11:0]                i_csr_addr,
  input  wire                        i_csr_wen,
  input  wire  [`TRAP_XLEN-1:0]      i_csr_wdata,
  output logic [`TRAP_XLEN-1:0]      o_csr_rdata,
  output logic                       o_mie
);

  trap_pkg::mstatus_t    mstatus_q;
  logic [`TRAP_XLEN-1:0] mepc_q;
  logic [`TRAP_XLEN-1:0] mcause_q;
  logic [`TRAP_XLEN-1:0] mtvec_q;

  logic                  wr_en;
  logic [11:0]           wr_addr;
  logic [`TRAP_XLEN-1:0] wr_data;
  trap_pkg::mstatus_t    mstatus_in;
  trap_pkg::mstatus_t    mstatus_wr;

  // shared address decode for both read ports
  function automatic logic [`TRAP_XLEN-1:0] csr_read(input logic [11:0] addr);
    case (addr)
      `TRAP_CSR_MSTATUS: csr_read = mstatus_q.raw;
      `TRAP_CSR_MEPC:    csr_read = mepc_q;
      `TRAP_CSR_MCAUSE:  csr_read = mcause_q;
      `TRAP_CSR_MTVEC:   csr_read = mtvec_q;
      default:           csr_read = '0;
    endcase
  endfunction

  // trap port wins the write slot
  always_comb begin
    wr_en   = trap.wen | i_csr_wen;
    wr_addr = trap.wen ? trap.addr : i_csr_addr;
    wr_data = trap.wen ? trap.wdata : i_csr_wdata;

    // WARL, keep mpp/mpie/mie only
    mstatus_in.raw     = wr_data;
    mstatus_wr.raw     = '0;
    mstatus_wr.f.mpp   = mstatus_in.f.mpp;
    mstatus_wr.f.mpie  = mstatus_in.f.mpie;
    mstatus_wr.f.mie   = mstatus_in.f.mie;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q.raw <= '0;
      mepc_q        <= '0;
      mcause_q      <= '0;
      mtvec_q       <= '0;
    end else if (wr_en) begin
      case (wr_addr)
        `TRAP_CSR_MSTATUS: mstatus_q <= mstatus_wr;
        `TRAP_CSR_MEPC:    mepc_q    <= {wr_data[`TRAP_XLEN-1:2], 2'b00};
        `TRAP_CSR_MCAUSE:  mcause_q  <= wr_data;
        `TRAP_CSR_MTVEC:   mtvec_q   <= {wr_data[`TRAP_XLEN-1:2], 2'b00};  // direct mode only
        default: ;
      endcase
    end
  end

  // registered trap read
  always_ff @(posedge clk) begin
    if (trap.ren) begin
      trap.rdata <= csr_read(trap.addr);
    end
  end

  always_comb begin
    o_csr_rdata = csr_read(i_csr_addr);  // pipeline reads are combinational
  end

  assign o_mie = mstatus_q.f.mie;

endmodule

`default_nettype wire

/* design/trap_subsystem.sv */
// trap subsystem top level
// sequencer and machine CSR file joined by the CSR access interface

`timescale 1ns/10ps
`default_nettype none

`include "trap_defs.svh"

module trap_subsystem (
  input  wire                        clk,
  input  wire                        rst,
  // trap request from the pipeline
  input  wire                        i_ena,
  input  wire  [7:0]                 i_opcode,
  input  wire  [`TRAP_XLEN-1:0]      i_pc,
  // redirect handshake
  output wire                        o_redirect,
  output wire  [`TRAP_XLEN-1:0]      o_target,
  input  wire                        i_ack,
  // pipeline CSR port
  input  wire  [11:0]                i_csr_addr,
  input  wire                        i_csr_wen,
  input  wire  [`TRAP_XLEN-1:0]      i_csr_wdata,
  output wire  [`TRAP_XLEN-1:0]      o_csr_rdata,
  output wire                        o_mie
);

  csr_access_if u_csr_if ();

  trap_sequencer u_seq (
    .clk        (clk),
    .rst        (rst),
    .i_ena      (i_ena),
    .i_opcode   (i_opcode),
    .i_pc       (i_pc),
    .i_ack      (i_ack),
    .o_redirect (o_redirect),
    .o_target   (o_target),
    .csr        (u_csr_if.master)
  );

  machine_csr_file u_csr (
    .clk         (clk),
    .rst         (rst),
    .trap        (u_csr_if.slave),
    .i_csr_addr  (i_csr_addr),
    .i_csr_wen   (i_csr_wen),
    .i_csr_wdata (i_csr_wdata),
    .o_csr_rdata (o_csr_rdata),
    .o_mie       (o_mie)
  );

endmodule

`default_nettype wire

/* test/trap_subsystem_checker.sv */
// protocol checks for the trap subsystem
// CSR strobe exclusion and the redirect/ack handshake

`timescale 1ns/10ps
`default_nettype none

`include "trap_defs.svh"

module trap_subsystem_checker (
  input wire                   clk,
  input wire                   rst,
  input wire                   i_ena,
  input wire [7:0]             i_opcode,
  input wire                   i_ren,
  input wire                   i_wen,
  input wire                   i_redirect,
  input wire [`TRAP_XLEN-1:0]  i_target,
  input wire                   i_ack
);

  trap_pkg::trap_kind_e busy_kind;  // trap in flight or none when idle
  int unsigned          fail_count = 0;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_kind <= trap_pkg::kind_none;
    end else if (busy_kind == trap_pkg::kind_none && i_ena) begin
      case (i_opcode)
        `TRAP_OP_ECALL: busy_kind <= trap_pkg::kind_ecall;
        `TRAP_OP_MRET:  busy_kind <= trap_pkg::kind_mret;
        default:        busy_kind <= trap_pkg::kind_timer;
      endcase
    end else if (i_redirect && i_ack) begin
      busy_kind <= trap_pkg::kind_none;
    end
  end

  a_no_read_write: assert property (
    @(posedge clk) disable iff (rst) !(i_ren && i_wen)
  ) else begin
    fail_count++;
    $error("CSR access port has read and write strobes high together");
  end

  // redirect waits for the ack
  a_redirect_held: assert property (
    @(posedge clk) disable iff (rst)
      (i_redirect && !i_ack) |=> (i_redirect && $stable(i_target))
  ) else begin
    fail_count++;
    $error("redirect dropped or target changed before ack");
  end

  a_redirect_drop: assert property (
    @(posedge clk) disable iff (rst) (i_redirect && i_ack) |=> !i_redirect
  ) else begin
    fail_count++;
    $error("redirect still high after a completed ack");
  end

  a_redirect_busy: assert property (
    @(posedge clk) disable iff (rst) i_redirect |-> (busy_kind != trap_pkg::kind_none)
  ) else begin
    fail_count++;
    $error("redirect raised with no trap in flight");
  end

endmodule

bind trap_subsystem trap_subsystem_checker u_checker (
  .clk        (clk),
  .rst        (rst),
  .i_ena      (i_ena),
  .i_opcode   (i_opcode),
  .i_ren      (u_csr_if.ren),
  .i_wen      (u_csr_if.wen),
  .i_redirect (o_redirect),
  .i_target   (o_target),
  .i_ack      (i_ack)
);

`default_nettype wire

/* test/trap_subsystem_tb.sv */
// testbench for the trap subsystem
// table of traps and CSR accesses, random PCs and ack delays

`timescale 1ns/10ps
`default_nettype none

`include "trap_defs.svh"

module trap_subsystem_tb;

  localparam int num_rows        = 8;
  localparam int max_delay       = 6;
  localparam int watchdog_cycles = num_rows * (11 + max_delay + 10) + 50;

  localparam logic [2:0] op_ecall     = 3'd0;
  localparam logic [2:0] op_timer     = 3'd1;
  localparam logic [2:0] op_mret      = 3'd2;
  localparam logic [2:0] op_csr_write = 3'd3;
  localparam logic [2:0] op_csr_read  = 3'd4;

  localparam logic [63:0] mstatus_mask = 64'h1888;  // mpp 12..11, mpie 7, mie 3
  localparam logic [63:0] cause_ecall  = 64'd11;
  localparam logic [63:0] cause_timer  = {1'b1, 63'd7};

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  i_ena;
  logic [7:0]            i_opcode;
  logic [`TRAP_XLEN-1:0] i_pc;
  logic                  i_ack;
  logic [11:0]           i_csr_addr;
  logic                  i_csr_wen;
  logic [`TRAP_XLEN-1:0] i_csr_wdata;
  wire                   o_redirect;
  wire  [`TRAP_XLEN-1:0] o_target;
  wire  [`TRAP_XLEN-1:0] o_csr_rdata;
  wire                   o_mie;

  // stimulus and expected values with one entry per row
  logic [2:0]  row_op          [num_rows];
  logic [63:0] row_pre_mstatus [num_rows];
  logic [63:0] row_pre_mtvec   [num_rows];
  logic [63:0] row_pre_mepc    [num_rows];
  logic [63:0] row_pc          [num_rows];
  int          row_delay       [num_rows];
  logic [63:0] row_exp_target  [num_rows];
  logic [63:0] row_exp_mstatus [num_rows];
  logic [63:0] row_exp_mtvec   [num_rows];
  logic [63:0] row_exp_mepc    [num_rows];
  logic [63:0] row_exp_mcause  [num_rows];

  trap_subsystem UUT (
    .clk         (clk),
    .rst         (rst),
    .i_ena       (i_ena),
    .i_opcode    (i_opcode),
    .i_pc        (i_pc),
    .o_redirect  (o_redirect),
    .o_target    (o_target),
    .i_ack       (i_ack),
    .i_csr_addr  (i_csr_addr),
    .i_csr_wen   (i_csr_wen),
    .i_csr_wdata (i_csr_wdata),
    .o_csr_rdata (o_csr_rdata),
    .o_mie       (o_mie)
  );

  always #50 clk = ~clk;

  function automatic logic [63:0] xorshift64(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  function automatic string op_name(input logic [2:0] op);
    case (op)
      op_ecall:     return "ecall";
      op_timer:     return "timer";
      op_mret:      return "mret";
      op_csr_write: return "csr_write";
      default:      return "csr_read";
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  task automatic set_row(input int idx, input logic [2:0] op, input logic [63:0] ms,
                         input logic [63:0] tvec, input logic [63:0] epc);
    row_op[idx]          = op;
    row_pre_mstatus[idx] = ms;
    row_pre_mtvec[idx]   = tvec;
    row_pre_mepc[idx]    = epc;
  endtask

  task automatic fill_table();
    set_row(0, op_csr_write, 64'hffff_ffff_ffff_ffff, 64'h0000_0000_8000_0fff, 64'h8000_0007);
    set_row(1, op_ecall,     64'h8,    64'h0000_0000_8000_0100, 64'h0);
    set_row(2, op_timer,     64'h0,    64'h0000_0000_8000_0203, 64'h0);
    set_row(3, op_mret,      64'h1880, 64'h0000_0000_8000_0100, 64'h0000_0000_8000_1236);
    set_row(4, op_ecall,     64'h0,    64'h0000_0000_0000_4000, 64'h0);
    set_row(5, op_mret,      64'h1808, 64'h0000_0000_0000_4000, 64'h0000_0000_0040_0010);
    set_row(6, op_csr_read,  64'h0,    64'h0,                   64'h0);
    set_row(7, op_timer,     64'h88,   64'hffff_ffff_ffff_fffe, 64'h0);
  endtask

  // running model of the four CSRs carried from row to row
  task automatic compute_expected();
    logic [63:0] ms;
    logic [63:0] tvec;
    logic [63:0] epc;
    logic [63:0] cause;
    logic [63:0] rng;
    int          i;
    ms    = '0;
    tvec  = '0;
    epc   = '0;
    cause = '0;
    rng   = 64'd98;
    for (i = 0; i < num_rows; i++) begin
      rng          = xorshift64(rng);
      row_pc[i]    = rng;
      rng          = xorshift64(rng);
      row_delay[i] = int'(rng % (max_delay + 1));
      row_exp_target[i] = '0;
      if (row_op[i] != op_csr_read) begin  // presets go through the WARL rules
        ms   = row_pre_mstatus[i] & mstatus_mask;
        tvec = row_pre_mtvec[i] & ~64'h3;
        epc  = row_pre_mepc[i] & ~64'h3;
      end
      if (row_op[i] == op_ecall || row_op[i] == op_timer) begin
        row_exp_target[i] = tvec;
        epc   = row_pc[i] & ~64'h3;
        cause = (row_op[i] == op_ecall) ? cause_ecall : cause_timer;
        ms    = 64'h1800 | (ms[3] ? 64'h80 : 64'h0);  // MPP=M, MPIE=MIE, MIE=0
      end else if (row_op[i] == op_mret) begin
        row_exp_target[i] = epc;
        ms = 64'h80 | (ms[7] ? 64'h8 : 64'h0);  // MIE=MPIE, MPIE=1, MPP=U
      end
      row_exp_mstatus[i] = ms;
      row_exp_mtvec[i]   = tvec;
      row_exp_mepc[i]    = epc;
      row_exp_mcause[i]  = cause;
    end
  endtask

  task automatic write_csr(input logic [11:0] addr, input logic [63:0] data);
    @(posedge clk);
    i_csr_addr  <= addr;
    i_csr_wen   <= 1'b1;
    i_csr_wdata <= data;
  endtask

  task automatic read_csr(input logic [11:0] addr, output logic [63:0] data);
    @(posedge clk);
    i_csr_addr <= addr;
    i_csr_wen  <= 1'b0;
    @(negedge clk);
    data = o_csr_rdata;
  endtask

  task automatic check_csrs(input string name, input int idx);
    logic [63:0] value;
    read_csr(`TRAP_CSR_MSTATUS, value);
    compare_value({name, " mstatus"}, row_exp_mstatus[idx], value);
    read_csr(`TRAP_CSR_MTVEC, value);
    compare_value({name, " mtvec"}, row_exp_mtvec[idx], value);
    read_csr(`TRAP_CSR_MEPC, value);
    compare_value({name, " mepc"}, row_exp_mepc[idx], value);
    read_csr(`TRAP_CSR_MCAUSE, value);
    compare_value({name, " mcause"}, row_exp_mcause[idx], value);
    compare_value({name, " o_mie"}, {63'd0, row_exp_mstatus[idx][3]}, {63'd0, o_mie});
  endtask

  task automatic run_trap(input string name, input int idx);
    logic [7:0] opcode;
    int         k;
    case (row_op[idx])
      op_ecall: opcode = `TRAP_OP_ECALL;
      op_mret:  opcode = `TRAP_OP_MRET;
      default:  opcode = 8'h5a;  // any other tag is a timer interrupt
    endcase
    @(posedge clk);
    i_csr_wen <= 1'b0;
    i_ena     <= 1'b1;
    i_opcode  <= opcode;
    i_pc      <= row_pc[idx];
    @(posedge clk);
    i_ena <= 1'b0;
    @(negedge clk);
    while (o_redirect !== 1'b1) begin  // watchdog catches a stuck sequencer
      @(negedge clk);
    end
    compare_value({name, " target"}, row_exp_target[idx], o_target);
    for (k = 0; k < row_delay[idx]; k++) begin
      @(posedge clk);
      i_ena    <= (k == 0);  // stray request while busy
      i_opcode <= `TRAP_OP_ECALL;
      i_pc     <= ~row_pc[idx];
      @(negedge clk);
      compare_value({name, " redirect held"}, 64'd1, {63'd0, o_redirect});
      compare_value({name, " target held"}, row_exp_target[idx], o_target);
    end
    @(posedge clk);
    i_ena <= 1'b0;
    i_ack <= 1'b1;
    @(posedge clk);
    i_ack <= 1'b0;
    @(negedge clk);
    compare_value({name, " redirect dropped"}, 64'd0, {63'd0, o_redirect});
  endtask

  always @(negedge clk) begin
    if (UUT.u_checker.fail_count != 0) begin
      $display("a protocol assertion in the bound checker failed");
      $display("Simulation finished: FAIL");
      $fatal(1, "protocol assertion failed");
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the test loop did not finish in %0d cycles", watchdog_cycles);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    string       name;
    logic [63:0] value;
    int          i;
    rst         = 1'b1;
    i_ena       = 1'b0;
    i_opcode    = '0;
    i_pc        = '0;
    i_ack       = 1'b0;
    i_csr_addr  = '0;
    i_csr_wen   = 1'b0;
    i_csr_wdata = '0;
    fill_table();
    compute_expected();
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    compare_value("reset o_redirect", 64'd0, {63'd0, o_redirect});
    compare_value("reset o_mie", 64'd0, {63'd0, o_mie});
    read_csr(`TRAP_CSR_MSTATUS, value);
    compare_value("reset mstatus", 64'd0, value);
    read_csr(`TRAP_CSR_MTVEC, value);
    compare_value("reset mtvec", 64'd0, value);
    read_csr(`TRAP_CSR_MEPC, value);
    compare_value("reset mepc", 64'd0, value);
    read_csr(`TRAP_CSR_MCAUSE, value);
    compare_value("reset mcause", 64'd0, value);

    for (i = 0; i < num_rows; i++) begin
      name = $sformatf("row%0d %s", i, op_name(row_op[i]));
      if (row_op[i] != op_csr_read) begin
        write_csr(`TRAP_CSR_MSTATUS, row_pre_mstatus[i]);
        write_csr(`TRAP_CSR_MTVEC, row_pre_mtvec[i]);
        write_csr(`TRAP_CSR_MEPC, row_pre_mepc[i]);
      end
      if (row_op[i] == op_ecall || row_op[i] == op_timer || row_op[i] == op_mret) begin
        run_trap(name, i);
      end
      if (row_op[i] == op_csr_read) begin
        read_csr(12'h7c0, value);
        compare_value({name, " unknown 7c0"}, 64'd0, value);
        read_csr(12'h343, value);  // mtval is not implemented
        compare_value({name, " unknown 343"}, 64'd0, value);
      end
      check_csrs(name, i);
    end

    if (UUT.u_checker.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* trap_subsystem.f */
+incdir+common
common/trap_pkg.sv
common/csr_access_if.sv
trap_ctrl/trap_sequencer.sv
csr_file/machine_csr_file.sv
design/trap_subsystem.sv
test/trap_subsystem_checker.sv
test/trap_subsystem_tb.sv

/* Bender.yml */
package:
  name: trap_subsystem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/trap_pkg.sv
      - common/csr_access_if.sv
      - trap_ctrl/trap_sequencer.sv
      - csr_file/machine_csr_file.sv
      - design/trap_subsystem.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/trap_subsystem_checker.sv
      - test/trap_subsystem_tb.sv
